/* Bender.yml */
package:
  name: cpu_core

sources:
  - rtl/cpu_pkg.sv
  - rtl/cpu_ctrl.sv
  - rtl/cpu_regs.sv
  - rtl/cpu_alu.sv
  - rtl/cpu_pc.sv
  - rtl/cpu_ramctl.sv
  - rtl/cpu_core.sv
  - target: test
    files:
      - tb/tb_cpu_core.sv

/* project.f */
rtl/cpu_pkg.sv
rtl/cpu_ctrl.sv
rtl/cpu_regs.sv
rtl/cpu_alu.sv
rtl/cpu_pc.sv
rtl/cpu_ramctl.sv
rtl/cpu_core.sv
tb/tb_cpu_core.sv

/* rtl/cpu_alu.sv */
// Arithmetic and logic unit plus the flag register.
// The result is combinational; flags load on an enabled cycle with flag_we.
// ADD and SUB set all four flags, the logic ops clear c and v.
// DEC is only used by DJNZ and reports its zero result on djnz_zero.
`timescale 1ns/10ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    cen,
    input  logic    rst_n,

    input  word_t   op_a,
    input  word_t   op_b,
    input  word_t   imm,
    input  alu_op_e alu_op,
    input  logic    flag_we,

    output word_t   dout,
    output flags_t  flags,
    output logic    djnz_zero
);

logic [WORD_W:0] sum;
word_t           res;
word_t           dec_val;
logic            carry, ovf;

assign dec_val = op_a - 1'b1;

always_comb begin
    sum   = '0;
    res   = op_a;
    carry = 1'b0;
    ovf   = 1'b0;
    case (alu_op)
        ALU_PASS_IMM: res = imm;
        ALU_ADD: begin
            sum   = {1'b0, op_a} + {1'b0, op_b};
            res   = sum[WORD_W-1:0];
            carry = sum[WORD_W];
            ovf   = (op_a[WORD_W-1] == op_b[WORD_W-1]) && (res[WORD_W-1] != op_a[WORD_W-1]);
        end
        ALU_SUB: begin
            // Top bit of the extended difference is the borrow
            sum   = {1'b0, op_a} - {1'b0, op_b};
            res   = sum[WORD_W-1:0];
            carry = sum[WORD_W];
            ovf   = (op_a[WORD_W-1] != op_b[WORD_W-1]) && (res[WORD_W-1] != op_a[WORD_W-1]);
        end
        ALU_AND: res = op_a & op_b;
        ALU_OR:  res = op_a | op_b;
        ALU_XOR: res = op_a ^ op_b;
        ALU_DEC: res = dec_val;
        default: res = op_a;
    endcase
end

assign dout      = res;
assign djnz_zero = dec_val == '0;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        flags <= '0;
    end else if (cen && flag_we) begin
        flags <= '{z: res == '0, c: carry, n: res[WORD_W-1], v: ovf};
    end
end

// DJNZ must leave the flags of the previous operation intact
a_dec_keeps_flags: assert property (@(posedge clk) disable iff (!rst_n)
    !(flag_we && alu_op == ALU_DEC));

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
// Top level of the 16-bit core.
// Connects the sequencer, register bank, ALU, PC and RAM controller to one
// synchronous RAM port and to the byte-wide register dump port.
// halted goes high once a HALT instruction has executed.
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic       clk,
    input  logic       cen,
    input  logic       rst_n,

    output addr_t      ram_addr,
    input  word_t      ram_dout,
    output word_t      ram_din,
    output logic [1:0] ram_we,

    // Register dump
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din,

    output logic       halted
);

reg_cmd_t reg_cmd;
alu_op_e  alu_op;
mem_cmd_e mem_cmd;
instr_t   instr;
flags_t   flags;
addr_t    pc;
word_t    alu_imm, alu_dout, rd_a, rd_b, load_data;
logic     sel_load, flag_we, djnz_zero;
logic     pc_step, pc_jump, mem_en;

cpu_ctrl u_ctrl (
    .clk, .cen, .rst_n,
    .instr, .flags, .djnz_zero,
    .reg_cmd, .sel_load,
    .alu_op, .alu_imm, .flag_we,
    .pc_step, .pc_jump,
    .mem_en, .mem_cmd,
    .halted
);

cpu_regs u_regs (
    .clk, .cen, .rst_n,
    .reg_cmd, .sel_load,
    .alu_dout, .load_data,
    .rd_a, .rd_b,
    .pc, .flags,
    .dmp_addr, .dmp_din
);

cpu_alu u_alu (
    .clk, .cen, .rst_n,
    .op_a   ( rd_a    ),
    .op_b   ( rd_b    ),
    .imm    ( alu_imm ),
    .alu_op, .flag_we,
    .dout   ( alu_dout ),
    .flags, .djnz_zero
);

cpu_pc u_pc (
    .clk, .cen, .rst_n,
    .pc_step, .pc_jump,
    .disp   ( instr.imm ),
    .pc
);

// rd_b carries the pointer register, rd_a the store data
cpu_ramctl u_ramctl (
    .clk, .cen, .rst_n,
    .mem_en, .mem_cmd, .pc,
    .ptr    ( rd_b ),
    .wdata  ( rd_a ),
    .ram_addr, .ram_dout, .ram_din, .ram_we,
    .instr, .load_data
);

endmodule

`default_nettype wire

/* rtl/cpu_ctrl.sv */
// Instruction sequencer.
// Walks FETCH, DECODE, EXEC and, for loads, MEM. The fetched word is decoded
// in DECODE and the decoded fields are held for EXEC and MEM, where they are
// turned into register, ALU, PC and memory strobes. Nothing moves with cen low.
`timescale 1ns/10ps
`default_nettype none

module cpu_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     cen,
    input  logic     rst_n,

    input  instr_t   instr,
    input  flags_t   flags,
    input  logic     djnz_zero,

    output reg_cmd_t reg_cmd,
    output logic     sel_load,
    output alu_op_e  alu_op,
    output word_t    alu_imm,
    output logic     flag_we,
    output logic     pc_step,
    output logic     pc_jump,
    output logic     mem_en,
    output mem_cmd_e mem_cmd,
    output logic     halted
);

typedef enum logic [1:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM} state_e;

state_e   state;
opcode_e  op_q;
reg_cmd_t reg_q, nx_reg;
alu_op_e  nx_alu;
logic     flag_q, nx_flag;
logic     exec, data_op, br_take;

// Decode of the word that arrives during DECODE
always_comb begin
    nx_reg = '{we: 1'b0, dst: instr.rd, src_a: instr.rd, src_b: instr.imm[7:5]};
    nx_reg.we = instr.opcode inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                     OP_LD, OP_DJNZ};
    nx_flag = instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    case (instr.opcode)
        OP_ADD:  nx_alu = ALU_ADD;
        OP_SUB:  nx_alu = ALU_SUB;
        OP_AND:  nx_alu = ALU_AND;
        OP_OR:   nx_alu = ALU_OR;
        OP_XOR:  nx_alu = ALU_XOR;
        OP_DJNZ: nx_alu = ALU_DEC;
        default: nx_alu = ALU_PASS_IMM;
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state   <= S_FETCH;
        op_q    <= opcode_e'(4'h0);
        reg_q   <= '0;
        alu_op  <= ALU_PASS_IMM;
        alu_imm <= '0;
        flag_q  <= 1'b0;
        halted  <= 1'b0;
    end else if (cen) begin
        case (state)
            S_FETCH: begin
                // A halted core parks here
                if (!halted) state <= S_DECODE;
            end
            S_DECODE: begin
                state   <= S_EXEC;
                op_q    <= instr.opcode;
                reg_q   <= nx_reg;
                alu_op  <= nx_alu;
                alu_imm <= word_t'(instr.imm);
                flag_q  <= nx_flag;
            end
            S_EXEC: begin
                state <= (op_q == OP_LD) ? S_MEM : S_FETCH;
                if (op_q == OP_HALT) halted <= 1'b1;
            end
            default: state <= S_FETCH;
        endcase
    end
end

assign exec    = state == S_EXEC;
assign data_op = op_q inside {OP_LD, OP_ST, OP_STB};
// DJNZ looks at the value being written back this same cycle
assign br_take = (op_q == OP_JR && flags.z) || (op_q == OP_DJNZ && !djnz_zero);

always_comb begin
    reg_cmd    = reg_q;
    // Loads write in MEM, everything else in EXEC
    reg_cmd.we = reg_q.we && (state == S_MEM || (exec && op_q != OP_LD));
end

assign sel_load = state == S_MEM;
assign flag_we  = exec && flag_q;
assign pc_step  = state == S_FETCH && !halted;
assign pc_jump  = exec && br_take;
assign mem_en   = pc_step || (exec && data_op);

always_comb begin
    case (op_q)
        OP_LD:   mem_cmd = MEM_READ;
        OP_ST:   mem_cmd = MEM_WRITE;
        default: mem_cmd = MEM_WRITE_B;
    endcase
    if (state == S_FETCH) mem_cmd = MEM_FETCH;
end

// A data access is always followed by a fetch or by the load write-back
a_no_back_to_back_data: assert property (@(posedge clk) disable iff (!rst_n)
    (cen && mem_en && mem_cmd != MEM_FETCH) |=> !(mem_en && mem_cmd != MEM_FETCH));

a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(halted));

endmodule

`default_nettype wire

/* rtl/cpu_pc.sv */
// Program counter, in words.
// Steps by one in the fetch cycle, so during EXEC it already points past
// the current instruction and a jump adds the signed displacement to that.
`timescale 1ns/10ps
`default_nettype none

module cpu_pc import cpu_pkg::*; (
    input  logic       clk,
    input  logic       cen,
    input  logic       rst_n,

    input  logic       pc_step,
    input  logic       pc_jump,
    input  logic [7:0] disp,

    output addr_t      pc
);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        pc <= RESET_PC;
    end else if (cen) begin
        if (pc_step)
            pc <= pc + 1'b1;
        else if (pc_jump)
            pc <= pc + {{(ADDR_W-8){disp[7]}}, disp};
    end
end

a_step_or_jump: assert property (@(posedge clk) disable iff (!rst_n)
    !(pc_step && pc_jump));

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
// Shared types and constants for the 16-bit core.
// Every RTL block pulls this in with a wildcard import in its header.
// Holds the instruction layout, the flag bits and the command encodings
// that pass between the sequencer and the datapath blocks.
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 24;
    localparam int NREGS  = 8;

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [$clog2(NREGS)-1:0] reg_idx_t;

    // Code 0 and the unlisted codes run as a one-word no-op
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_STB  = 4'h9,
        OP_JR   = 4'ha,
        OP_DJNZ = 4'hb,
        OP_HALT = 4'hf
    } opcode_e;

    // rs sits in imm[7:5]
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        logic       spare;
        logic [7:0] imm;
    } instr_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic v;
    } flags_t;

    typedef enum logic [2:0] {
        ALU_PASS_IMM,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_DEC
    } alu_op_e;

    typedef struct packed {
        logic     we;
        reg_idx_t dst;
        reg_idx_t src_a;
        reg_idx_t src_b;
    } reg_cmd_t;

    typedef enum logic [1:0] {
        MEM_FETCH,
        MEM_READ,
        MEM_WRITE,
        MEM_WRITE_B
    } mem_cmd_e;

    // Dump port byte map above the register bytes
    localparam logic [7:0] DUMP_PC    = 8'd16;
    localparam logic [7:0] DUMP_FLAGS = 8'd19;

    localparam addr_t RESET_PC = '0;

endpackage

`default_nettype wire

/* rtl/cpu_ramctl.sv */
// RAM controller for the shared instruction and data port.
// Fetches use the PC, data accesses the zero-extended register pointer.
// The RAM answers one enabled cycle later: the word is passed straight
// through in that cycle and held afterwards. STB replicates the byte and
// picks the lane from address bit 0.
`timescale 1ns/10ps
`default_nettype none

module cpu_ramctl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       cen,
    input  logic       rst_n,

    input  logic       mem_en,
    input  mem_cmd_e   mem_cmd,
    input  addr_t      pc,
    input  word_t      ptr,
    input  word_t      wdata,

    output addr_t      ram_addr,
    input  word_t      ram_dout,
    output word_t      ram_din,
    output logic [1:0] ram_we,

    output instr_t     instr,
    output word_t      load_data
);

logic   fetch_d, read_d;
instr_t instr_q;
word_t  load_q;

always_comb begin
    ram_addr = (mem_cmd == MEM_FETCH) ? pc : addr_t'(ptr);
    ram_din  = (mem_cmd == MEM_WRITE_B) ? {2{wdata[7:0]}} : wdata;
    ram_we   = 2'b00;
    if (mem_en) begin
        case (mem_cmd)
            MEM_WRITE:   ram_we = 2'b11;
            MEM_WRITE_B: ram_we = ptr[0] ? 2'b10 : 2'b01;
            default:     ram_we = 2'b00;
        endcase
    end
end

// Which kind of answer is on ram_dout this cycle
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        fetch_d <= 1'b0;
        read_d  <= 1'b0;
    end else if (cen) begin
        fetch_d <= mem_en && mem_cmd == MEM_FETCH;
        read_d  <= mem_en && mem_cmd == MEM_READ;
    end
end

always_ff @(posedge clk) begin
    if (cen && fetch_d) instr_q <= instr_t'(ram_dout);
    if (cen && read_d)  load_q  <= ram_dout;
end

assign instr     = fetch_d ? instr_t'(ram_dout) : instr_q;
assign load_data = read_d ? ram_dout : load_q;

endmodule

`default_nettype wire

/* rtl/cpu_regs.sv */
// Register bank with eight 16-bit registers.
// Two combinational read ports feed the ALU and the RAM controller. The
// single write port takes the ALU result or, for loads, the RAM data.
// The byte-wide dump port shows the registers, the PC and the flags.
`timescale 1ns/10ps
`default_nettype none

module cpu_regs import cpu_pkg::*; (
    input  logic       clk,
    input  logic       cen,
    input  logic       rst_n,

    input  reg_cmd_t   reg_cmd,
    input  logic       sel_load,
    input  word_t      alu_dout,
    input  word_t      load_data,
    output word_t      rd_a,
    output word_t      rd_b,

    input  addr_t      pc,
    input  flags_t     flags,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din
);

word_t regs [NREGS];
word_t dmp_word;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        regs <= '{default: '0};
    end else if (cen && reg_cmd.we) begin
        regs[reg_cmd.dst] <= sel_load ? load_data : alu_dout;
    end
end

assign rd_a = regs[reg_cmd.src_a];
assign rd_b = regs[reg_cmd.src_b];

// Two bytes per register, low byte first
assign dmp_word = regs[dmp_addr[3:1]];

always_comb begin
    case (dmp_addr)
        DUMP_PC:        dmp_din = pc[7:0];
        DUMP_PC + 8'd1: dmp_din = pc[15:8];
        DUMP_PC + 8'd2: dmp_din = pc[23:16];
        DUMP_FLAGS:     dmp_din = {4'h0, flags};
        default: begin
            if (dmp_addr < DUMP_PC)
                dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
            else
                dmp_din = 8'h00;
        end
    endcase
end

endmodule

`default_nettype wire

/* tb/tb_cpu_core.sv */
// Testbench for the 16-bit core.
// A behavioral RAM holds each test program. Every table row is run from reset
// until HALT, then the whole dump port and one RAM word are compared against
// the row's expected state. Each program runs once with cen high and once
// with random cen.
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

localparam int N_PROG   = 7;
localparam int N_ROWS   = 2 * N_PROG;
localparam int PROG_LEN = 8;
localparam int PERIOD   = 4;
// 12 cycles per word, four times that under random cen, plus reset and dumps
localparam int ROW_CYCLES = PROG_LEN * 12 * 4 + 8 + 16;

logic       clk      = 1'b0;
logic       cen      = 1'b0;
logic       rst_n    = 1'b0;
addr_t      ram_addr;
word_t      ram_dout = '0;
word_t      ram_din;
logic [1:0] ram_we;
logic [7:0] dmp_addr = '0;
logic [7:0] dmp_din;
logic       halted;

// Test table with one index per row
string  name_tbl  [N_ROWS];
bit     rcen_tbl  [N_ROWS];
word_t  prog_tbl  [N_ROWS][PROG_LEN];
word_t  regs_tbl  [N_ROWS][NREGS];
flags_t flags_tbl [N_ROWS];
addr_t  pc_tbl    [N_ROWS];
int     maddr_tbl [N_ROWS];  // -1 when no RAM word is checked
word_t  mword_tbl [N_ROWS];

word_t  mem [256];
integer seed = 32'hbc8a9a34;
integer rnd;
bit     rand_cen = 1'b0;

cpu_core i_dut (
    .clk, .cen, .rst_n,
    .ram_addr, .ram_dout, .ram_din, .ram_we,
    .dmp_addr, .dmp_din,
    .halted
);

always #(PERIOD / 2) clk = ~clk;

always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    cen = rand_cen ? rnd[0] : 1'b1;
end

// Synchronous RAM with byte lanes and one enabled cycle of read latency
always @(posedge clk) begin
    if (cen) begin
        if (ram_we[0]) mem[ram_addr[7:0]][7:0]  <= ram_din[7:0];
        if (ram_we[1]) mem[ram_addr[7:0]][15:8] <= ram_din[15:8];
        ram_dout <= mem[ram_addr[7:0]];
    end
end

task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error");
endtask

function automatic word_t asm_imm(input opcode_e op, input int rd, input logic [7:0] imm);
    return {op, 3'(rd), 1'b0, imm};
endfunction

// rs goes into the top three bits of imm
function automatic word_t asm_reg(input opcode_e op, input int rd, input int rs);
    return {op, 3'(rd), 1'b0, 3'(rs), 5'b0};
endfunction

task automatic build_table();
    name_tbl[0]  = "ldi_add_sub";
    prog_tbl[0]  = '{asm_imm(OP_LDI, 1, 8'h7f), asm_imm(OP_LDI, 2, 8'h7f),
                     asm_reg(OP_ADD, 1, 2), asm_imm(OP_LDI, 3, 8'h00),
                     asm_imm(OP_LDI, 4, 8'h01), asm_reg(OP_SUB, 3, 4),
                     asm_imm(OP_HALT, 0, 8'h00), 16'h0000};
    regs_tbl[0]  = '{16'h0000, 16'h00fe, 16'h007f, 16'hffff,
                     16'h0001, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[0] = 4'b0110;
    pc_tbl[0]    = 24'd7;
    maddr_tbl[0] = -1;
    // 0x8000 + 0x8000 sets zero, carry and overflow at once
    name_tbl[1]  = "add_ovf_zero";
    prog_tbl[1]  = '{asm_imm(OP_LDI, 0, 8'h04), asm_reg(OP_LD, 1, 0),
                     asm_reg(OP_ADD, 1, 1), asm_imm(OP_HALT, 0, 8'h00),
                     16'h8000, 16'h0000, 16'h0000, 16'h0000};
    regs_tbl[1]  = '{16'h0004, 16'h0000, 16'h0000, 16'h0000,
                     16'h0000, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[1] = 4'b1101;
    pc_tbl[1]    = 24'd4;
    maddr_tbl[1] = -1;
    name_tbl[2]  = "logic_ops";
    prog_tbl[2]  = '{asm_imm(OP_LDI, 1, 8'hf0), asm_imm(OP_LDI, 2, 8'h3c),
                     asm_imm(OP_LDI, 4, 8'h01), asm_reg(OP_SUB, 0, 4),
                     asm_reg(OP_AND, 1, 2), asm_reg(OP_OR, 2, 4),
                     asm_reg(OP_XOR, 0, 2), asm_imm(OP_HALT, 0, 8'h00)};
    regs_tbl[2]  = '{16'hffc2, 16'h0030, 16'h003d, 16'h0000,
                     16'h0001, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[2] = 4'b0010;
    pc_tbl[2]    = 24'd8;
    maddr_tbl[2] = -1;
    // Fill at 0x41 is 0xbe41 and STB to the odd address swaps only its high byte
    name_tbl[3]  = "st_ld_stb";
    prog_tbl[3]  = '{asm_imm(OP_LDI, 0, 8'h40), asm_imm(OP_LDI, 1, 8'ha5),
                     asm_reg(OP_ST, 1, 0), asm_reg(OP_LD, 2, 0),
                     asm_imm(OP_LDI, 3, 8'h41), asm_reg(OP_STB, 1, 3),
                     asm_imm(OP_HALT, 0, 8'h00), 16'h0000};
    regs_tbl[3]  = '{16'h0040, 16'h00a5, 16'h00a5, 16'h0041,
                     16'h0000, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[3] = 4'b0000;
    pc_tbl[3]    = 24'd7;
    maddr_tbl[3] = 8'h41;
    mword_tbl[3] = 16'ha541;
    name_tbl[4]  = "jr_taken_and_not";
    prog_tbl[4]  = '{asm_reg(OP_SUB, 1, 1), asm_imm(OP_JR, 0, 8'h01),
                     asm_imm(OP_LDI, 2, 8'h11), asm_imm(OP_LDI, 3, 8'h22),
                     asm_reg(OP_ADD, 3, 3), asm_imm(OP_JR, 0, 8'h01),
                     asm_imm(OP_LDI, 4, 8'h33), asm_imm(OP_HALT, 0, 8'h00)};
    regs_tbl[4]  = '{16'h0000, 16'h0000, 16'h0000, 16'h0044,
                     16'h0033, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[4] = 4'b0000;
    pc_tbl[4]    = 24'd8;
    maddr_tbl[4] = -1;
    // Five passes of step 7 back to the ADD at word 2
    name_tbl[5]  = "djnz_loop";
    prog_tbl[5]  = '{asm_imm(OP_LDI, 1, 8'h05), asm_imm(OP_LDI, 2, 8'h07),
                     asm_reg(OP_ADD, 3, 2), asm_imm(OP_DJNZ, 1, 8'hfe),
                     asm_imm(OP_HALT, 0, 8'h00), 16'h0000, 16'h0000, 16'h0000};
    regs_tbl[5]  = '{16'h0000, 16'h0000, 16'h0007, 16'h0023,
                     16'h0000, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[5] = 4'b0000;
    pc_tbl[5]    = 24'd5;
    maddr_tbl[5] = -1;
    // The overflowing ADD leaves z, c and v set for the OR to clear
    name_tbl[6]  = "or_clears_cv";
    prog_tbl[6]  = '{asm_imm(OP_LDI, 0, 8'h05), asm_reg(OP_LD, 1, 0),
                     asm_reg(OP_ADD, 1, 1), asm_reg(OP_OR, 2, 0),
                     asm_imm(OP_HALT, 0, 8'h00), 16'h8000, 16'h0000, 16'h0000};
    regs_tbl[6]  = '{16'h0005, 16'h0000, 16'h0005, 16'h0000,
                     16'h0000, 16'h0000, 16'h0000, 16'h0000};
    flags_tbl[6] = 4'b0000;
    pc_tbl[6]    = 24'd5;
    maddr_tbl[6] = -1;
    for (int r = 0; r < N_PROG; r++) begin
        rcen_tbl[r]           = 1'b0;
        name_tbl[r + N_PROG]  = {name_tbl[r], "_rcen"};
        rcen_tbl[r + N_PROG]  = 1'b1;
        prog_tbl[r + N_PROG]  = prog_tbl[r];
        regs_tbl[r + N_PROG]  = regs_tbl[r];
        flags_tbl[r + N_PROG] = flags_tbl[r];
        pc_tbl[r + N_PROG]    = pc_tbl[r];
        maddr_tbl[r + N_PROG] = maddr_tbl[r];
        mword_tbl[r + N_PROG] = mword_tbl[r];
    end
endtask

// Registers little-endian at 0..15, PC at 16..18, flags at 19
function automatic logic [7:0] want_byte(input int row, input logic [7:0] a);
    word_t r;
    r = regs_tbl[row][a[3:1]];
    if (a < 8'd16)
        return a[0] ? r[15:8] : r[7:0];
    else if (a < 8'd19)
        return pc_tbl[row][8 * (a - 8'd16) +: 8];
    else if (a == 8'd19)
        return {4'h0, flags_tbl[row]};
    return 8'h00;
endfunction

task automatic load_ram(input int row);
    for (int a = 0; a < 256; a++)
        mem[a] = {~a[7:0], a[7:0]};
    for (int a = 0; a < PROG_LEN; a++)
        mem[a] = prog_tbl[row][a];
endtask

task automatic check_dump(input int row, input bit at_reset);
    logic [7:0] want;
    string      tag;
    tag = at_reset ? {name_tbl[row], "_reset"} : name_tbl[row];
    for (int a = 0; a < 24; a++) begin
        dmp_addr = 8'(a);
        #1;
        want = at_reset ? 8'h00 : want_byte(row, 8'(a));
        assert (dmp_din === want) else
            fail_stop($sformatf("ERR %s dump byte %0d: expected %h, actual %h",
                tag, a, want, dmp_din));
    end
endtask

task automatic run_row(input int row);
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    rand_cen = rcen_tbl[row];
    load_ram(row);
    assert (ram_we == 2'b00) else
        fail_stop($sformatf("ERR %s ram_we in reset: expected 00, actual %b",
            name_tbl[row], ram_we));
    // The reset dump is read while the reset cycles count down
    fork
        check_dump(row, 1'b1);
        repeat (8) @(posedge clk);
    join
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    while (!halted) @(negedge clk);
    check_dump(row, 1'b0);
    if (maddr_tbl[row] >= 0) begin
        assert (mem[maddr_tbl[row]] === mword_tbl[row]) else
            fail_stop($sformatf("ERR %s ram[%0h]: expected %h, actual %h", name_tbl[row],
                maddr_tbl[row], mword_tbl[row], mem[maddr_tbl[row]]));
    end
endtask

initial begin
    #(N_ROWS * ROW_CYCLES * PERIOD);
    fail_stop("Timeout: the core never reached HALT in the time allowed for the tests");
end

initial begin
    build_table();
    for (int r = 0; r < N_ROWS; r++) begin
        run_row(r);
        $display("%s: ok", name_tbl[r]);
    end
    $display(">>> PASS");
    $finish;
end

endmodule

`default_nettype wire
